/* design/dcache_pkg.sv */
// 32-bit byte addresses, one 64-bit word per line, 2 ways of 64 sets; memory side is word wide
package dcache_pkg;

    parameter int unsigned ADDR_W   = 32;
    parameter int unsigned DATA_W   = 64;
    parameter int unsigned STRB_W   = DATA_W / 8;
    parameter int unsigned OFFSET_W = 3;
    parameter int unsigned INDEX_W  = 6;
    parameter int unsigned SETS     = 1 << INDEX_W;
    parameter int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        logic [STRB_W-1:0] strb;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_rsp_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

endpackage

/* design/dcache_way_ram.sv */
// one entry per set; asynchronous read, write lands at the next clock, all entries cleared on reset
module dcache_way_ram #(
    parameter int unsigned DEPTH = 64,
    parameter type entry_t = dcache_pkg::word_t
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  dcache_pkg::index_t addr_i,
    input  logic               we_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    entry_t mem_q [DEPTH];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q <= '{default: '0};
        end else if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem_q[addr_i];

    // a write to an unknown set would corrupt the whole way
    a_we_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        we_i |-> !$isunknown(addr_i)
    );

endmodule

/* design/dcache_lru.sv */
// two ways only, so one bit per set names the victim; a touch shows on the next cycle
module dcache_lru (
    input  logic               clk,
    input  logic               arst_n_i,
    input  dcache_pkg::index_t index_i,
    input  logic               touch_i,
    input  logic               touched_way_i,
    output logic               victim_way_o
);

    import dcache_pkg::*;

    // bit set means way 1 is the older one
    logic [SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lru_q <= '0;
        end else if (touch_i) begin
            lru_q[index_i] <= ~touched_way_i;
        end
    end

    assign victim_way_o = lru_q[index_i];

endmodule

/* design/dcache_mem_port.sv */
// memory must accept every request it gets; one credit pulse frees one slot, at most CREDITS held
module dcache_mem_port #(
    parameter int unsigned CREDITS = 2
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          send_i,
    input  dcache_pkg::mem_op_e           op_i,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  dcache_pkg::word_t             wdata_i,
    output logic                          can_send_o,
    input  logic                          mem_credit_i,
    output dcache_pkg::mem_req_t          mem_req_o
);

    import dcache_pkg::*;

    localparam int unsigned CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0]  credit_q;
    logic              req_valid_q;
    mem_op_e           req_op_q;
    logic [ADDR_W-1:0] req_addr_q;
    word_t             req_wdata_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q    <= CNT_W'(CREDITS);
            req_valid_q <= 1'b0;
        end else begin
            credit_q    <= credit_q + CNT_W'(mem_credit_i) - CNT_W'(send_i);
            req_valid_q <= send_i;
        end
    end

    always_ff @(posedge clk) begin
        if (send_i) begin
            req_op_q    <= op_i;
            req_addr_q  <= {addr_i[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
            req_wdata_q <= wdata_i;
        end
    end

    assign can_send_o = (credit_q != '0);
    assign mem_req_o  = '{valid: req_valid_q, op: req_op_q, addr: req_addr_q, wdata: req_wdata_q};

    // memory returned more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        credit_q <= CNT_W'(CREDITS)
    );

    a_send_needs_credit: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        send_i |-> can_send_o
    );

endmodule

/* design/dcache_ctrl.sv */
// CPU must hold its request until done; a miss refills into the LRU way, then repeats the lookup
module dcache_ctrl (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  dcache_pkg::cpu_req_t            cpu_req_i,
    output dcache_pkg::cpu_rsp_t            cpu_rsp_o,
    input  dcache_pkg::tag_entry_t [1:0]    tag_rd_i,
    input  dcache_pkg::word_t [1:0]         data_rd_i,
    output logic [1:0]                      tag_we_o,
    output logic [1:0]                      data_we_o,
    output dcache_pkg::tag_entry_t          tag_wr_o,
    output dcache_pkg::word_t               data_wr_o,
    output dcache_pkg::index_t              index_o,
    output logic                            lru_touch_o,
    output logic                            lru_way_o,
    input  logic                            victim_way_i,
    input  logic                            can_send_i,
    output logic                            send_o,
    output dcache_pkg::mem_op_e             op_o,
    output logic [dcache_pkg::ADDR_W-1:0]   addr_o,
    output dcache_pkg::word_t               wdata_o,
    input  dcache_pkg::mem_rsp_t            mem_rsp_i
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_ISSUE,
        ST_RF_ISSUE,
        ST_RF_WAIT
    } state_e;

    state_e     state_q;
    state_e     state_d;
    tag_t       req_tag;
    index_t     req_index;
    logic [1:0] hit;
    logic       hit_way;
    logic       lookup_hit;
    tag_entry_t victim;
    word_t      merged;

    assign req_tag    = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
    assign req_index  = cpu_req_i.addr[OFFSET_W +: INDEX_W];
    assign hit[0]     = tag_rd_i[0].valid && (tag_rd_i[0].tag == req_tag);
    assign hit[1]     = tag_rd_i[1].valid && (tag_rd_i[1].tag == req_tag);
    assign hit_way    = hit[1];
    assign lookup_hit = (state_q == ST_LOOKUP) && (|hit);
    assign victim     = tag_rd_i[victim_way_i];

    // byte merge of the store into the hit word
    always_comb begin
        merged = data_rd_i[hit_way];
        for (int b = 0; b < STRB_W; b++) begin
            if (cpu_req_i.strb[b]) begin
                merged[8*b +: 8] = cpu_req_i.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req_i.valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (|hit) begin
                    state_d = ST_IDLE;
                end else if (victim.valid && victim.dirty) begin
                    state_d = ST_WB_ISSUE;
                end else begin
                    state_d = ST_RF_ISSUE;
                end
            end
            ST_WB_ISSUE: begin
                if (can_send_i) begin
                    state_d = ST_RF_ISSUE;
                end
            end
            ST_RF_ISSUE: begin
                if (can_send_i) begin
                    state_d = ST_RF_WAIT;
                end
            end
            ST_RF_WAIT: begin
                if (mem_rsp_i.valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // refill writes a clean line; a store hit rewrites the same tag as dirty
    always_comb begin
        tag_we_o  = '0;
        data_we_o = '0;
        tag_wr_o  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
        data_wr_o = mem_rsp_i.rdata;
        if (lookup_hit && cpu_req_i.write) begin
            tag_we_o[hit_way]  = 1'b1;
            data_we_o[hit_way] = 1'b1;
            tag_wr_o.dirty     = 1'b1;
            data_wr_o          = merged;
        end else if ((state_q == ST_RF_WAIT) && mem_rsp_i.valid) begin
            tag_we_o[victim_way_i]  = 1'b1;
            data_we_o[victim_way_i] = 1'b1;
        end
    end

    assign index_o     = req_index;
    assign lru_touch_o = lookup_hit;
    assign lru_way_o   = hit_way;
    assign cpu_rsp_o   = '{done: lookup_hit, rdata: data_rd_i[hit_way]};

    assign send_o  = ((state_q == ST_WB_ISSUE) || (state_q == ST_RF_ISSUE)) && can_send_i;
    assign op_o    = (state_q == ST_WB_ISSUE) ? MEM_WRITE : MEM_READ;
    // victim address comes back from its stored tag
    assign addr_o  = (state_q == ST_WB_ISSUE) ? {victim.tag, req_index, OFFSET_W'(0)}
                                              : cpu_req_i.addr;
    assign wdata_o = data_rd_i[victim_way_i];

    // a line never sits in both ways of its set
    a_done_single_way: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cpu_rsp_o.done |-> $onehot(hit)
    );

endmodule

/* design/dcache_top.sv */
// single requester toward memory, so write-back and refill go out in order with no arbiter
module dcache_top #(
    parameter int unsigned CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output dcache_pkg::cpu_rsp_t cpu_rsp_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_credit_i,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);

    import dcache_pkg::*;

    tag_entry_t [1:0]  tag_rd;
    word_t [1:0]       data_rd;
    logic [1:0]        tag_we;
    logic [1:0]        data_we;
    tag_entry_t        tag_wr;
    word_t             data_wr;
    index_t            index;
    logic              lru_touch;
    logic              lru_way;
    logic              victim_way;
    logic              can_send;
    logic              send;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;

    dcache_ctrl i_dcache_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .tag_rd_i     (tag_rd),
        .data_rd_i    (data_rd),
        .tag_we_o     (tag_we),
        .data_we_o    (data_we),
        .tag_wr_o     (tag_wr),
        .data_wr_o    (data_wr),
        .index_o      (index),
        .lru_touch_o  (lru_touch),
        .lru_way_o    (lru_way),
        .victim_way_i (victim_way),
        .can_send_i   (can_send),
        .send_o       (send),
        .op_o         (op),
        .addr_o       (addr),
        .wdata_o      (wdata),
        .mem_rsp_i    (mem_rsp_i)
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_way_ram #(.DEPTH(SETS), .entry_t(tag_entry_t)) i_tag_ram (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .addr_i   (index),
            .we_i     (tag_we[w]),
            .wdata_i  (tag_wr),
            .rdata_o  (tag_rd[w])
        );

        dcache_way_ram #(.DEPTH(SETS), .entry_t(word_t)) i_data_ram (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .addr_i   (index),
            .we_i     (data_we[w]),
            .wdata_i  (data_wr),
            .rdata_o  (data_rd[w])
        );
    end

    dcache_lru i_dcache_lru (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .index_i       (index),
        .touch_i       (lru_touch),
        .touched_way_i (lru_way),
        .victim_way_o  (victim_way)
    );

    dcache_mem_port #(.CREDITS(CREDITS)) i_dcache_mem_port (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .send_i       (send),
        .op_i         (op),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .can_send_o   (can_send),
        .mem_credit_i (mem_credit_i),
        .mem_req_o    (mem_req_o)
    );

endmodule

/* tests/tb_dcache.sv */
// 400 random loads and stores over 4 tags and 8 sets after a directed LRU check; CREDITS fixed at 2
module tb_dcache;

    import dcache_pkg::*;

    localparam int unsigned CREDITS    = 2;
    localparam logic [31:0] SEED       = 32'h5d7b;
    localparam int          N_TRANS    = 400;
    localparam int          N_DIRECTED = 14;
    localparam int          TXN_CYCLES = 40;
    localparam int          MAX_CYCLES = (N_TRANS + N_DIRECTED) * TXN_CYCLES;
    localparam int          DELAY_MIN  = 1;
    localparam int          N_SETS     = 8;
    localparam int          N_SLOTS    = 4 * N_SETS;

    logic     clk = 1'b0;
    logic     arst_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    logic     mem_credit = 1'b0;
    mem_rsp_t mem_rsp = '0;

    // CPU view of memory, and what backing memory really holds
    word_t model_mem [N_SLOTS];
    word_t backing [N_SLOTS];

    logic [31:0] cpu_rng = SEED;
    // memory delays draw from their own stream
    logic [31:0] mem_rng = ~SEED;
    int          cycle = 0;
    int          in_flight = 0;
    int          req_count = 0;
    int          wb_count = 0;
    logic [31:0] last_wb_addr = '0;
    int          credit_due [$];
    int          rsp_slot [$];

    dcache_top #(.CREDITS(CREDITS)) i_dcache_top (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .cpu_req_i    (cpu_req),
        .cpu_rsp_o    (cpu_rsp),
        .mem_req_o    (mem_req),
        .mem_credit_i (mem_credit),
        .mem_rsp_i    (mem_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic tag_t tag_of(input int t);
        case (t)
            0: return tag_t'(23'h000000);
            1: return tag_t'(23'h000001);
            2: return tag_t'(23'h1abcd2);
            default: return tag_t'(23'h7fffff);
        endcase
    endfunction

    // slot is tag * 8 + set, sets spread over the index range
    function automatic logic [ADDR_W-1:0] addr_of(input int slot, input logic [2:0] off);
        return {tag_of(slot / N_SETS), index_t'((slot % N_SETS) * 5), off};
    endfunction

    function automatic int slot_of(input logic [ADDR_W-1:0] addr);
        for (int i = 0; i < N_SLOTS; i++) begin
            if (addr_of(i, 3'b000) == {addr[ADDR_W-1:3], 3'b000}) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic word_t fill_pattern(input int slot);
        logic [ADDR_W-1:0] a;
        a = addr_of(slot, 3'b000);
        return {a, ~a} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                          input logic [STRB_W-1:0] strb);
        word_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // holds the request until done, then checks or updates the model
    task automatic access(input string name, input int slot, input logic wr,
                          input logic [2:0] off, input word_t wdata,
                          input logic [STRB_W-1:0] strb, output int latency);
        latency       = 0;
        cpu_req.valid = 1'b1;
        cpu_req.write = wr;
        cpu_req.addr  = addr_of(slot, off);
        cpu_req.wdata = wdata;
        cpu_req.strb  = strb;
        @(negedge clk);
        while (!cpu_rsp.done) begin
            latency++;
            if (latency > TXN_CYCLES) begin
                $display("%s got no done within %0d cycles", name, TXN_CYCLES);
                stop_with_failure();
            end
            @(negedge clk);
        end
        if (wr) begin
            model_mem[slot] = merge_bytes(model_mem[slot], wdata, strb);
        end else begin
            compare(name, model_mem[slot], cpu_rsp.rdata);
        end
        @(negedge clk);
        cpu_req.valid = 1'b0;
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with requests still pending", MAX_CYCLES);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // credits come back 1 to 4 cycles late and read-lines are answered in order
    always @(negedge clk) begin : mem_model
        int slot;
        mem_credit    = 1'b0;
        mem_rsp.valid = 1'b0;
        if (mem_req.valid) begin
            req_count++;
            in_flight++;
            if (in_flight > int'(CREDITS)) begin
                $display("more than %0d memory requests in flight", CREDITS);
                stop_with_failure();
            end
            slot = slot_of(mem_req.addr);
            if (slot < 0) begin
                $display("memory request to address %h outside the test set", mem_req.addr);
                stop_with_failure();
            end
            mem_rng = lcg_next(mem_rng);
            credit_due.push_back(cycle + DELAY_MIN + int'(mem_rng[17:16]));
            if (mem_req.op == MEM_WRITE) begin
                compare("write-line data", model_mem[slot], mem_req.wdata);
                backing[slot] = mem_req.wdata;
                wb_count++;
                last_wb_addr = mem_req.addr;
            end else begin
                rsp_slot.push_back(slot);
            end
        end
        if ((credit_due.size() > 0) && (credit_due[0] <= cycle)) begin
            void'(credit_due.pop_front());
            mem_credit = 1'b1;
            in_flight--;
        end
        if (rsp_slot.size() > 0) begin
            mem_rsp.valid = 1'b1;
            mem_rsp.rdata = backing[rsp_slot.pop_front()];
        end
    end

    initial begin
        int          lat;
        int          count0;
        int          slot;
        logic        wr;
        logic [2:0]  off;
        word_t       wdata;
        logic [31:0] strb_bits;
        arst_n  = 1'b0;
        cpu_req = '0;
        for (int i = 0; i < N_SLOTS; i++) begin
            model_mem[i] = fill_pattern(i);
            backing[i]   = fill_pattern(i);
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // A in slot 0 and B in slot 8 share set 0
        access("fill A", 0, 1'b0, 3'd0, '0, '0, lat);
        access("fill B", 8, 1'b0, 3'd4, '0, '0, lat);
        count0 = req_count;
        repeat (4) begin
            access("hit A", 0, 1'b0, 3'd2, '0, '0, lat);
            compare("hit A latency", 64'(0), 64'(lat));
            access("hit B", 8, 1'b0, 3'd6, '0, '0, lat);
            compare("hit B latency", 64'(0), 64'(lat));
        end
        compare("requests during hits", 64'(count0), 64'(req_count));

        // B dirty and older, so C in slot 16 must evict it
        access("store B", 8, 1'b1, 3'd0, 64'hdead_beef_0123_4567, 8'h3c, lat);
        access("touch A", 0, 1'b0, 3'd0, '0, '0, lat);
        count0 = wb_count;
        access("miss C", 16, 1'b0, 3'd0, '0, '0, lat);
        compare("write-lines on evict", 64'(count0 + 1), 64'(wb_count));
        compare("evicted address", 64'(addr_of(8, 3'd0)), 64'(last_wb_addr));
        count0 = req_count;
        access("A kept", 0, 1'b0, 3'd0, '0, '0, lat);
        compare("requests for A kept", 64'(count0), 64'(req_count));

        for (int n = 0; n < N_TRANS; n++) begin
            cpu_rng     = lcg_next(cpu_rng);
            slot        = int'(cpu_rng[20:16]);
            wr          = cpu_rng[24];
            off         = cpu_rng[27:25];
            cpu_rng     = lcg_next(cpu_rng);
            wdata[63:32] = cpu_rng;
            cpu_rng     = lcg_next(cpu_rng);
            wdata[31:0] = cpu_rng;
            cpu_rng     = lcg_next(cpu_rng);
            strb_bits   = cpu_rng;
            access($sformatf("txn %0d", n), slot, wr, off, wdata, strb_bits[23:16], lat);
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* sim.f */
design/dcache_pkg.sv
design/dcache_way_ram.sv
design/dcache_lru.sv
design/dcache_mem_port.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f sim.f -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
